// ==== hdl/riscv_mem_pkg.sv ====
package riscv_mem_pkg;

  // Host side byte address, top bit selects status space on the core data bus
  localparam int HOST_ADDR_WIDTH = 16;

  // Memory view of a core data address
  typedef struct packed {
    logic [31-HOST_ADDR_WIDTH:0] upper;
    logic [HOST_ADDR_WIDTH-1:0]  offset;
  } dbus_mem_addr_t;

  // Status view of the same address, 32-bit words
  typedef struct packed {
    logic [31-HOST_ADDR_WIDTH:0] upper;
    logic                        io_sel;
    logic [HOST_ADDR_WIDTH-4:0]  word;
    logic [1:0]                  lane;
  } dbus_io_addr_t;

  typedef union packed {
    dbus_mem_addr_t mem;
    dbus_io_addr_t  io;
  } dbus_addr_u;

  // Size encoding: 0 byte, 1 half, 2 word
  typedef struct packed {
    logic        valid;
    logic        wr;
    dbus_addr_u  addr;
    logic [31:0] wdata;
    logic [1:0]  size;
  } dbus_cmd_t;

  typedef struct packed {
    logic        valid;
    logic        error;
    logic [31:0] rdata;
  } dbus_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } ibus_cmd_t;

  typedef struct packed {
    logic        valid;
    logic        error;
    logic [31:0] inst;
  } ibus_rsp_t;

  typedef struct packed {
    logic                       en;
    logic [HOST_ADDR_WIDTH-4:0] word;
    logic [3:0]                 mask;
    logic [31:0]                data;
  } stat_wr_t;

endpackage

// ==== hdl/dual_port_ram.sv ====
`timescale 1ns/100ps

module dual_port_ram #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 12,
  localparam int STRB_WIDTH = DATA_WIDTH/8
) (
  input  logic                  clk,

  input  logic                  ena,
  input  logic                  rena,
  input  logic [STRB_WIDTH-1:0] wena,
  input  logic [ADDR_WIDTH-1:0] addra,
  input  logic [DATA_WIDTH-1:0] dina,
  output logic [DATA_WIDTH-1:0] douta,

  input  logic                  enb,
  input  logic                  renb,
  input  logic [STRB_WIDTH-1:0] wenb,
  input  logic [ADDR_WIDTH-1:0] addrb,
  input  logic [DATA_WIDTH-1:0] dinb,
  output logic [DATA_WIDTH-1:0] doutb
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // Both ports in one process, port B wins a same-byte collision
  always_ff @(posedge clk) begin
    if (ena) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (wena[i]) begin
          mem[addra][i*8 +: 8] <= dina[i*8 +: 8];
        end
      end
      if (rena) begin
        douta <= mem[addra];
      end
    end

    if (enb) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (wenb[i]) begin
          mem[addrb][i*8 +: 8] <= dinb[i*8 +: 8];
        end
      end
      if (renb) begin
        doutb <= mem[addrb];
      end
    end
  end

endmodule

// ==== hdl/simple_dual_port_ram.sv ====
`timescale 1ns/100ps

module simple_dual_port_ram #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 10,
  localparam int STRB_WIDTH = DATA_WIDTH/8
) (
  input  logic                  clk,

  input  logic                  wena,
  input  logic [STRB_WIDTH-1:0] wea,
  input  logic [ADDR_WIDTH-1:0] addra,
  input  logic [DATA_WIDTH-1:0] dina,

  input  logic                  enb,
  input  logic [ADDR_WIDTH-1:0] addrb,
  output logic [DATA_WIDTH-1:0] doutb
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (wena) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (wea[i]) begin
          mem[addra][i*8 +: 8] <= dina[i*8 +: 8];
        end
      end
    end
  end

  // Read returns the old line on a same-address write
  always_ff @(posedge clk) begin
    if (enb) begin
      doutb <= mem[addrb];
    end
  end

endmodule

// ==== hdl/ibus_fetch.sv ====
`timescale 1ns/100ps

module ibus_fetch import riscv_mem_pkg::*; #(
  parameter int DATA_WIDTH      = 64,
  parameter int IMEM_SIZE_BYTES = 8192,
  localparam int LINE_BITS      = $clog2(DATA_WIDTH/8),
  localparam int IMEM_AW        = $clog2(IMEM_SIZE_BYTES),
  localparam int IMEM_LINE_AW   = IMEM_AW - LINE_BITS
) (
  input  logic                    clk,
  input  logic                    core_reset,
  input  ibus_cmd_t               ibus_cmd,
  output ibus_rsp_t               ibus_rsp,
  output logic                    imem_en,
  output logic [IMEM_LINE_AW-1:0] imem_addr,
  input  logic [DATA_WIDTH-1:0]   imem_rdata
);

  logic                    rsp_valid;
  logic                    fetch_err;
  logic [LINE_BITS-3:0]    word_sel_q;
  logic [DATA_WIDTH-1:0]   line_shifted;

  assign imem_en   = ibus_cmd.valid;
  assign imem_addr = ibus_cmd.pc[IMEM_AW-1:LINE_BITS];

  always_ff @(posedge clk) begin
    if (core_reset) begin
      rsp_valid <= 1'b0;
      fetch_err <= 1'b0;
    end else begin
      rsp_valid <= ibus_cmd.valid;
      // Any pc bit above the memory size is a fault
      fetch_err <= fetch_err || (ibus_cmd.valid && ((ibus_cmd.pc >> IMEM_AW) != '0));
    end
  end

  // Word position inside the line, needed when the line comes back
  always_ff @(posedge clk) begin
    word_sel_q <= ibus_cmd.pc[LINE_BITS-1:2];
  end

  assign line_shifted = imem_rdata >> {word_sel_q, 5'd0};

  assign ibus_rsp.valid = rsp_valid;
  assign ibus_rsp.error = fetch_err;
  assign ibus_rsp.inst  = line_shifted[31:0];

endmodule

// ==== hdl/dbus_bridge.sv ====
`timescale 1ns/100ps

module dbus_bridge import riscv_mem_pkg::*; #(
  parameter int DATA_WIDTH      = 64,
  parameter int DMEM_SIZE_BYTES = 32768,
  parameter int STAT_ADDR_WIDTH = 1,
  localparam int STRB_WIDTH     = DATA_WIDTH/8,
  localparam int LINE_BITS      = $clog2(STRB_WIDTH),
  localparam int DMEM_AW        = $clog2(DMEM_SIZE_BYTES),
  localparam int DMEM_LINE_AW   = DMEM_AW - LINE_BITS
) (
  input  logic                       clk,
  input  logic                       core_reset,
  input  dbus_cmd_t                  dbus_cmd,
  output dbus_rsp_t                  dbus_rsp,

  output logic                       dmem_en,
  output logic                       dmem_ren,
  output logic [STRB_WIDTH-1:0]      dmem_wen,
  output logic [DMEM_LINE_AW-1:0]    dmem_addr,
  output logic [DATA_WIDTH-1:0]      dmem_wdata,
  input  logic [DATA_WIDTH-1:0]      dmem_rdata,

  output stat_wr_t                   stat_wr,
  output logic                       stat_ren,
  output logic [HOST_ADDR_WIDTH-4:0] stat_word,
  input  logic [31:0]                stat_core_data
);

  logic                  is_io;
  logic                  mem_err;
  logic                  io_err;
  logic                  acc_err;
  logic                  is_store;
  logic [3:0]            word_mask;
  logic [LINE_BITS-3:0]  word_sel;
  logic [LINE_BITS-3:0]  word_sel_q;
  logic                  is_io_q;
  logic                  rsp_valid;
  logic                  data_err;
  logic [DATA_WIDTH-1:0] line_shifted;

  assign is_io    = dbus_cmd.addr.io.io_sel;
  assign is_store = dbus_cmd.valid && dbus_cmd.wr;

  assign mem_err = (dbus_cmd.addr.mem.upper != '0) ||
                   ((dbus_cmd.addr.mem.offset >> DMEM_AW) != '0);

  // Two 32-bit words per status register
  assign io_err = (dbus_cmd.addr.io.upper != '0) ||
                  ((dbus_cmd.addr.io.word >> (STAT_ADDR_WIDTH + 1)) != '0);

  assign acc_err = dbus_cmd.valid && (is_io ? io_err : mem_err);

  // Byte lanes touched by a store within its 32-bit word
  always_comb begin
    word_mask = 4'h0;
    if (is_store) begin
      case (dbus_cmd.size)
        2'd0:    word_mask = 4'b0001 << dbus_cmd.addr.mem.offset[1:0];
        2'd1:    word_mask = 4'b0011 << dbus_cmd.addr.mem.offset[1:0];
        default: word_mask = 4'b1111;
      endcase
    end
  end

  assign word_sel = dbus_cmd.addr.mem.offset[LINE_BITS-1:2];

  // Memory port A
  assign dmem_en    = dbus_cmd.valid && !is_io && !mem_err;
  assign dmem_ren   = !dbus_cmd.wr;
  assign dmem_addr  = dbus_cmd.addr.mem.offset[DMEM_AW-1:LINE_BITS];
  assign dmem_wen   = {{(STRB_WIDTH-4){1'b0}}, word_mask} << {word_sel, 2'b00};
  assign dmem_wdata = {{(DATA_WIDTH-32){1'b0}}, dbus_cmd.wdata} << {word_sel, 5'd0};

  // Status bank
  assign stat_word    = dbus_cmd.addr.io.word;
  assign stat_ren     = dbus_cmd.valid && !dbus_cmd.wr && is_io && !io_err;
  assign stat_wr.en   = is_store && is_io && !io_err;
  assign stat_wr.word = dbus_cmd.addr.io.word;
  assign stat_wr.mask = word_mask;
  assign stat_wr.data = dbus_cmd.wdata;

  always_ff @(posedge clk) begin
    if (core_reset) begin
      rsp_valid <= 1'b0;
      data_err  <= 1'b0;
    end else begin
      rsp_valid <= dbus_cmd.valid;
      data_err  <= data_err || acc_err;
    end
  end

  always_ff @(posedge clk) begin
    is_io_q    <= is_io;
    word_sel_q <= word_sel;
  end

  assign line_shifted = dmem_rdata >> {word_sel_q, 5'd0};

  assign dbus_rsp.valid = rsp_valid;
  assign dbus_rsp.error = data_err;
  assign dbus_rsp.rdata = is_io_q ? stat_core_data : line_shifted[31:0];

endmodule

// ==== hdl/status_regs.sv ====
`timescale 1ns/100ps

module status_regs import riscv_mem_pkg::*; #(
  parameter int STAT_ADDR_WIDTH = 1,
  localparam int NUM_REGS       = 2**STAT_ADDR_WIDTH
) (
  input  logic                       clk,
  input  logic                       core_reset,

  input  stat_wr_t                   stat_wr,
  input  logic                       stat_ren,
  input  logic [HOST_ADDR_WIDTH-4:0] stat_word,
  output logic [31:0]                stat_core_data,

  input  logic                       stat_rd_en,
  input  logic [HOST_ADDR_WIDTH-1:0] stat_rd_addr,
  output logic [63:0]                stat_rd_data,
  output logic                       stat_rd_ready,

  output logic [63:0]                core_msg_data,
  output logic                       core_msg_valid
);

  logic [63:0]                regs [NUM_REGS];
  logic [STAT_ADDR_WIDTH-1:0] wr_idx;
  logic [STAT_ADDR_WIDTH-1:0] core_idx;
  logic [STAT_ADDR_WIDTH-1:0] host_idx;
  logic [7:0]                 wr_mask;
  logic [63:0]                wr_data;
  logic                       msg_armed;

  // Core addresses 32-bit words, host addresses bytes of 64-bit registers
  assign wr_idx   = stat_wr.word[STAT_ADDR_WIDTH:1];
  assign core_idx = stat_word[STAT_ADDR_WIDTH:1];
  assign host_idx = stat_rd_addr[STAT_ADDR_WIDTH+2:3];

  assign wr_mask = {4'h0, stat_wr.mask} << {stat_wr.word[0], 2'b00};
  assign wr_data = {32'd0, stat_wr.data} << {stat_wr.word[0], 5'd0};

  always_ff @(posedge clk) begin
    if (core_reset) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= 64'd0;
      end
    end else if (stat_wr.en) begin
      for (int i = 0; i < 8; i++) begin
        if (wr_mask[i]) begin
          regs[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
        end
      end
    end
  end

  // Single read port, core load takes it over the host
  always_ff @(posedge clk) begin
    if (stat_ren) begin
      stat_core_data <= stat_word[0] ? regs[core_idx][63:32] : regs[core_idx][31:0];
    end else if (stat_rd_en) begin
      stat_rd_data <= regs[host_idx];
    end
  end

  assign stat_rd_ready = !stat_ren;

  // Low word of register 0 arms, high word fires the message
  always_ff @(posedge clk) begin
    if (core_reset) begin
      msg_armed      <= 1'b0;
      core_msg_valid <= 1'b0;
    end else begin
      core_msg_valid <= 1'b0;
      if (stat_wr.en) begin
        if (!msg_armed && (stat_wr.word == '0)) begin
          msg_armed <= 1'b1;
        end else if (msg_armed && (stat_wr.word == 1)) begin
          msg_armed      <= 1'b0;
          core_msg_valid <= 1'b1;
        end
      end
    end
  end

  assign core_msg_data = regs[0];

endmodule

// ==== hdl/riscvcore_mem.sv ====
`timescale 1ns/100ps

module riscvcore_mem import riscv_mem_pkg::*; #(
  parameter int DATA_WIDTH      = 64,
  parameter int IMEM_SIZE_BYTES = 8192,
  parameter int DMEM_SIZE_BYTES = 32768,
  parameter int STAT_ADDR_WIDTH = 1,
  localparam int STRB_WIDTH     = DATA_WIDTH/8
) (
  input  logic                       clk,
  input  logic                       core_reset,

  input  logic [STRB_WIDTH-1:0]      ins_dma_wen,
  input  logic [HOST_ADDR_WIDTH-1:0] ins_dma_addr,
  input  logic [DATA_WIDTH-1:0]      ins_dma_wr_data,

  input  logic                       data_dma_en,
  input  logic                       data_dma_ren,
  input  logic [STRB_WIDTH-1:0]      data_dma_wen,
  input  logic [HOST_ADDR_WIDTH-1:0] data_dma_addr,
  input  logic [DATA_WIDTH-1:0]      data_dma_wr_data,
  output logic [DATA_WIDTH-1:0]      data_dma_rd_data,

  input  logic                       stat_rd_en,
  input  logic [HOST_ADDR_WIDTH-1:0] stat_rd_addr,
  output logic [63:0]                stat_rd_data,
  output logic                       stat_rd_ready,

  input  ibus_cmd_t                  ibus_cmd,
  output ibus_rsp_t                  ibus_rsp,
  input  dbus_cmd_t                  dbus_cmd,
  output dbus_rsp_t                  dbus_rsp,

  output logic [63:0]                core_msg_data,
  output logic                       core_msg_valid,
  output logic                       interrupt
);

  localparam int LINE_BITS    = $clog2(STRB_WIDTH);
  localparam int IMEM_AW      = $clog2(IMEM_SIZE_BYTES);
  localparam int DMEM_AW      = $clog2(DMEM_SIZE_BYTES);
  localparam int IMEM_LINE_AW = IMEM_AW - LINE_BITS;
  localparam int DMEM_LINE_AW = DMEM_AW - LINE_BITS;

  logic                       imem_en;
  logic [IMEM_LINE_AW-1:0]    imem_addr;
  logic [DATA_WIDTH-1:0]      imem_rdata;
  logic                       dmem_en;
  logic                       dmem_ren;
  logic [STRB_WIDTH-1:0]      dmem_wen;
  logic [DMEM_LINE_AW-1:0]    dmem_addr;
  logic [DATA_WIDTH-1:0]      dmem_wdata;
  logic [DATA_WIDTH-1:0]      dmem_rdata;
  stat_wr_t                   stat_wr;
  logic                       stat_ren;
  logic [HOST_ADDR_WIDTH-4:0] stat_word;
  logic [31:0]                stat_core_data;
  logic                       out_of_bound;

  // Host accesses beyond each region
  assign out_of_bound =
      (data_dma_en && ((data_dma_addr >> DMEM_AW) != '0)) ||
      ((|ins_dma_wen) && ((ins_dma_addr >> IMEM_AW) != '0)) ||
      (stat_rd_en && ((stat_rd_addr >> (STAT_ADDR_WIDTH + 3)) != '0));

  // Sticky until the core is reset
  always_ff @(posedge clk) begin
    if (core_reset) begin
      interrupt <= 1'b0;
    end else begin
      interrupt <= interrupt || out_of_bound;
    end
  end

  ibus_fetch #(
    .DATA_WIDTH      (DATA_WIDTH),
    .IMEM_SIZE_BYTES (IMEM_SIZE_BYTES)
  ) u_ibus_fetch (
    .clk        (clk),
    .core_reset (core_reset),
    .ibus_cmd   (ibus_cmd),
    .ibus_rsp   (ibus_rsp),
    .imem_en    (imem_en),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata)
  );

  dbus_bridge #(
    .DATA_WIDTH      (DATA_WIDTH),
    .DMEM_SIZE_BYTES (DMEM_SIZE_BYTES),
    .STAT_ADDR_WIDTH (STAT_ADDR_WIDTH)
  ) u_dbus_bridge (
    .clk            (clk),
    .core_reset     (core_reset),
    .dbus_cmd       (dbus_cmd),
    .dbus_rsp       (dbus_rsp),
    .dmem_en        (dmem_en),
    .dmem_ren       (dmem_ren),
    .dmem_wen       (dmem_wen),
    .dmem_addr      (dmem_addr),
    .dmem_wdata     (dmem_wdata),
    .dmem_rdata     (dmem_rdata),
    .stat_wr        (stat_wr),
    .stat_ren       (stat_ren),
    .stat_word      (stat_word),
    .stat_core_data (stat_core_data)
  );

  status_regs #(
    .STAT_ADDR_WIDTH (STAT_ADDR_WIDTH)
  ) u_status_regs (
    .clk            (clk),
    .core_reset     (core_reset),
    .stat_wr        (stat_wr),
    .stat_ren       (stat_ren),
    .stat_word      (stat_word),
    .stat_core_data (stat_core_data),
    .stat_rd_en     (stat_rd_en),
    .stat_rd_addr   (stat_rd_addr),
    .stat_rd_data   (stat_rd_data),
    .stat_rd_ready  (stat_rd_ready),
    .core_msg_data  (core_msg_data),
    .core_msg_valid (core_msg_valid)
  );

  // Port A for the core, port B for host DMA
  dual_port_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (DMEM_LINE_AW)
  ) u_dmem (
    .clk   (clk),
    .ena   (dmem_en),
    .rena  (dmem_ren),
    .wena  (dmem_wen),
    .addra (dmem_addr),
    .dina  (dmem_wdata),
    .douta (dmem_rdata),
    .enb   (data_dma_en),
    .renb  (data_dma_ren),
    .wenb  (data_dma_wen),
    .addrb (data_dma_addr[DMEM_AW-1:LINE_BITS]),
    .dinb  (data_dma_wr_data),
    .doutb (data_dma_rd_data)
  );

  simple_dual_port_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (IMEM_LINE_AW)
  ) u_imem (
    .clk   (clk),
    .wena  (|ins_dma_wen),
    .wea   (ins_dma_wen),
    .addra (ins_dma_addr[IMEM_AW-1:LINE_BITS]),
    .dina  (ins_dma_wr_data),
    .enb   (imem_en),
    .addrb (imem_addr),
    .doutb (imem_rdata)
  );

endmodule

// ==== verification/tb_riscvcore_mem.sv ====
`timescale 1ns/100ps

module tb_riscvcore_mem import riscv_mem_pkg::*; ();

  localparam int    RESET_CYCLES    = 5;
  localparam int    CYCLES_PER_LINE = 20;
  localparam string TRACE_FILE      = "verification/mem_trace.txt";

  logic                       clk;
  logic                       core_reset;
  logic [7:0]                 ins_dma_wen;
  logic [HOST_ADDR_WIDTH-1:0] ins_dma_addr;
  logic [63:0]                ins_dma_wr_data;
  logic                       data_dma_en;
  logic                       data_dma_ren;
  logic [7:0]                 data_dma_wen;
  logic [HOST_ADDR_WIDTH-1:0] data_dma_addr;
  logic [63:0]                data_dma_wr_data;
  logic [63:0]                data_dma_rd_data;
  logic                       stat_rd_en;
  logic [HOST_ADDR_WIDTH-1:0] stat_rd_addr;
  logic [63:0]                stat_rd_data;
  logic                       stat_rd_ready;
  ibus_cmd_t                  ibus_cmd;
  ibus_rsp_t                  ibus_rsp;
  dbus_cmd_t                  dbus_cmd;
  dbus_rsp_t                  dbus_rsp;
  logic [63:0]                core_msg_data;
  logic                       core_msg_valid;
  logic                       interrupt;

  int    trace_lines;
  int    test_errors;
  int    n_pass;
  int    n_fail;
  string test_name;

  riscvcore_mem #(
    .DATA_WIDTH      (64),
    .IMEM_SIZE_BYTES (8192),
    .DMEM_SIZE_BYTES (32768),
    .STAT_ADDR_WIDTH (1)
  ) dut_i (
    .clk              (clk),
    .core_reset       (core_reset),
    .ins_dma_wen      (ins_dma_wen),
    .ins_dma_addr     (ins_dma_addr),
    .ins_dma_wr_data  (ins_dma_wr_data),
    .data_dma_en      (data_dma_en),
    .data_dma_ren     (data_dma_ren),
    .data_dma_wen     (data_dma_wen),
    .data_dma_addr    (data_dma_addr),
    .data_dma_wr_data (data_dma_wr_data),
    .data_dma_rd_data (data_dma_rd_data),
    .stat_rd_en       (stat_rd_en),
    .stat_rd_addr     (stat_rd_addr),
    .stat_rd_data     (stat_rd_data),
    .stat_rd_ready    (stat_rd_ready),
    .ibus_cmd         (ibus_cmd),
    .ibus_rsp         (ibus_rsp),
    .dbus_cmd         (dbus_cmd),
    .dbus_rsp         (dbus_rsp),
    .core_msg_data    (core_msg_data),
    .core_msg_valid   (core_msg_valid),
    .interrupt        (interrupt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run length follows from the trace size
  initial begin
    wait (trace_lines > 0);
    #((trace_lines * CYCLES_PER_LINE + RESET_CYCLES) * 10);
    $display("Watchdog expired, the trace did not finish in time");
    $display("Test FAILED");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_inputs();
    ins_dma_wen      = '0;
    ins_dma_addr     = '0;
    ins_dma_wr_data  = '0;
    data_dma_en      = 1'b0;
    data_dma_ren     = 1'b0;
    data_dma_wen     = '0;
    data_dma_addr    = '0;
    data_dma_wr_data = '0;
    stat_rd_en       = 1'b0;
    stat_rd_addr     = '0;
    ibus_cmd         = '0;
    dbus_cmd         = '0;
  endtask

  task automatic fail_test(input string what);
    $display("error %s: %s", test_name, what);
    test_errors++;
  endtask

  task automatic check_value(input string what, input logic [63:0] expv,
                             input logic [63:0] actv);
    if (actv !== expv) begin
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, expv, actv);
      test_errors++;
    end
  endtask

  task automatic apply_reset();
    core_reset = 1'b1;
    repeat (RESET_CYCLES) next_cycle();
    check_value("core_msg_valid", 64'd0, {63'd0, core_msg_valid});
    check_value("interrupt", 64'd0, {63'd0, interrupt});
    check_value("ibus valid", 64'd0, {63'd0, ibus_rsp.valid});
    check_value("dbus valid", 64'd0, {63'd0, dbus_rsp.valid});
    check_value("fetch error", 64'd0, {63'd0, ibus_rsp.error});
    check_value("data error", 64'd0, {63'd0, dbus_rsp.error});
    check_value("stat_rd_ready", 64'd1, {63'd0, stat_rd_ready});
    core_reset = 1'b0;
  endtask

  task automatic core_fetch(input logic [31:0] pc);
    ibus_cmd.valid = 1'b1;
    ibus_cmd.pc    = pc;
    next_cycle();
    ibus_cmd = '0;
    if (ibus_rsp.valid !== 1'b1) fail_test("no fetch response one cycle after the command");
  endtask

  task automatic core_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [1:0] size, input logic wr);
    dbus_cmd.valid = 1'b1;
    dbus_cmd.wr    = wr;
    dbus_cmd.addr  = addr;
    dbus_cmd.wdata = wdata;
    dbus_cmd.size  = size;
    next_cycle();
    dbus_cmd = '0;
    if (dbus_rsp.valid !== 1'b1) fail_test("no data bus response one cycle after the command");
  endtask

  // Leaves the host request pending until the bank grants it
  task automatic wait_stat_ready();
    int waited;
    waited = 0;
    #1;
    while (stat_rd_ready !== 1'b1 && waited < 16) begin
      next_cycle();
      #1;
      waited++;
    end
    if (stat_rd_ready !== 1'b1) fail_test("stat_rd_ready never returned high");
  endtask

  task automatic host_stat_read(input logic [63:0] addr, input logic [63:0] expv);
    stat_rd_en   = 1'b1;
    stat_rd_addr = addr[HOST_ADDR_WIDTH-1:0];
    wait_stat_ready();
    next_cycle();
    stat_rd_en = 1'b0;
    check_value("host status data", expv, stat_rd_data);
  endtask

  task automatic run_op(input logic [63:0] op, input logic [63:0] a, input logic [63:0] d,
                        input logic [63:0] g, input logic [63:0] e);
    case (op)
      "iwr": begin
        ins_dma_wen     = g[7:0];
        ins_dma_addr    = a[HOST_ADDR_WIDTH-1:0];
        ins_dma_wr_data = d;
        next_cycle();
        ins_dma_wen = '0;
      end
      "fetch": begin
        core_fetch(a[31:0]);
        check_value("instruction", e, {32'd0, ibus_rsp.inst});
      end
      "fbad": core_fetch(a[31:0]);
      "ierr": check_value("fetch error", e, {63'd0, ibus_rsp.error});
      "dwr", "drd", "hbad": begin
        data_dma_en      = 1'b1;
        data_dma_ren     = (op != "dwr");
        data_dma_wen     = (op == "dwr") ? g[7:0] : 8'h00;
        data_dma_addr    = a[HOST_ADDR_WIDTH-1:0];
        data_dma_wr_data = d;
        next_cycle();
        data_dma_en  = 1'b0;
        data_dma_wen = '0;
        if (op == "drd") check_value("DMA read data", e, data_dma_rd_data);
      end
      "st": core_access(a[31:0], d[31:0], g[1:0], 1'b1);
      "ld": begin
        core_access(a[31:0], 32'd0, g[1:0], 1'b0);
        check_value("load data", e, {32'd0, dbus_rsp.rdata});
      end
      "lbad": core_access(a[31:0], 32'd0, g[1:0], 1'b0);
      "derr": check_value("data error", e, {63'd0, dbus_rsp.error});
      "sst": begin
        core_access(a[31:0], d[31:0], g[1:0], 1'b1);
        check_value("core_msg_valid", e, {63'd0, core_msg_valid});
        next_cycle();
        if (core_msg_valid !== 1'b0) fail_test("core_msg_valid stayed high a second cycle");
      end
      "mdat": check_value("core_msg_data", e, core_msg_data);
      "srd": host_stat_read(a, e);
      "sld": begin
        // Core status load and host read in the same cycle
        dbus_cmd.valid = 1'b1;
        dbus_cmd.wr    = 1'b0;
        dbus_cmd.addr  = a[31:0];
        dbus_cmd.size  = 2'd2;
        stat_rd_en     = 1'b1;
        stat_rd_addr   = d[HOST_ADDR_WIDTH-1:0];
        #1;
        if (stat_rd_ready !== 1'b0) fail_test("stat_rd_ready high during a core status load");
        next_cycle();
        dbus_cmd = '0;
        if (dbus_rsp.valid !== 1'b1) fail_test("no response to the core status load");
        check_value("core status data", e, {32'd0, dbus_rsp.rdata});
        wait_stat_ready();
        next_cycle();
        stat_rd_en = 1'b0;
        check_value("host status data", g, stat_rd_data);
      end
      "irq": check_value("interrupt", e, {63'd0, interrupt});
      "rst": apply_reset();
      default: fail_test("unknown operation in the trace file");
    endcase
  endtask

  function automatic int count_trace_lines();
    int                 cfd;
    int                 n;
    logic [8*128-1:0]   buffer;
    n   = 0;
    cfd = $fopen(TRACE_FILE, "r");
    if (cfd != 0) begin
      while ($fgets(buffer, cfd) != 0) n++;
      $fclose(cfd);
    end
    return n;
  endfunction

  initial begin
    int               fd;
    int               code;
    int               line_no;
    int               errors_before;
    bit               done;
    logic [63:0]      op;
    logic [63:0]      f_addr;
    logic [63:0]      f_data;
    logic [63:0]      f_arg;
    logic [63:0]      f_exp;
    logic [8*128-1:0] rest_of_line;

    clear_inputs();
    core_reset  = 1'b1;
    test_errors = 0;
    n_pass      = 0;
    n_fail      = 0;
    line_no     = 0;
    done        = 1'b0;
    trace_lines = count_trace_lines();

    test_name = "reset";
    apply_reset();
    if (test_errors == 0) begin
      $display("pass %s", test_name);
      n_pass++;
    end else begin
      $display("fail %s", test_name);
      n_fail++;
    end

    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the trace file %s", TRACE_FILE);
      n_fail++;
      done = 1'b1;
    end

    while (!done) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1) begin
        done = 1'b1;
      end else if (op == "#") begin
        code = $fgets(rest_of_line, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h", f_addr, f_data, f_arg, f_exp);
        line_no++;
        test_name = $sformatf("%0s_%0d", op, line_no);
        errors_before = test_errors;
        if (code != 4) begin
          fail_test("trace line has fewer than five fields");
        end else begin
          run_op(op, f_addr, f_data, f_arg, f_exp);
        end
        if (test_errors == errors_before) begin
          $display("pass %s", test_name);
          n_pass++;
        end else begin
          $display("fail %s", test_name);
          n_fail++;
        end
      end
    end
    if (fd != 0) $fclose(fd);

    $display("Tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0 && line_no > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/riscv_mem_pkg.sv
hdl/dual_port_ram.sv
hdl/simple_dual_port_ram.sv
hdl/ibus_fetch.sv
hdl/dbus_bridge.sv
hdl/status_regs.sv
hdl/riscvcore_mem.sv
verification/tb_riscvcore_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the riscvcore_mem testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_riscvcore_mem \
    -f vlog.f -Mdir obj_dir -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > "$LOG" 2>&1 \
  || { echo "Build or simulation run failed, see build.log and $LOG"; exit 1; }

grep -q "Test FAILED" "$LOG" \
  && { echo "Simulation reported failures, see $LOG"; exit 1; }

grep -q "Test OK" "$LOG" \
  || { echo "Simulation ended without a result, see $LOG"; exit 1; }

echo "Simulation passed"

// ==== verification/mem_trace.txt ====
# op addr data arg expect, all fields hex
# arg is the DMA byte mask or the store size; for sld data is the host address, arg its data
iwr 0000 1111111122222222 ff 0
iwr 0008 33333333deadbeef ff 0
iwr 0010 aaaaaaaabbbbbbbb 0f 0
fetch 0000 0 0 22222222
fetch 0004 0 0 11111111
fetch 000c 0 0 33333333
fetch 0010 0 0 bbbbbbbb
ierr 0 0 0 0
dwr 0100 0123456789abcdef ff 0
st 0100 000000aa 0 0
st 0106 bbcc0000 1 0
st 0108 cafef00d 2 0
drd 0100 0 0 bbcc456789abcdaa
ld 0104 0 2 bbcc4567
ld 0100 0 2 89abcdaa
ld 0108 0 2 cafef00d
derr 0 0 0 0
sst 8000 11223344 2 0
sst 8004 55667788 2 1
mdat 0 0 0 5566778811223344
srd 0000 0 0 5566778811223344
sst 800c 9abcdef0 2 0
sst 8004 00000001 2 0
mdat 0 0 0 0000000111223344
sld 800c 0008 9abcdef000000000 9abcdef0
fbad 2000 0 0 0
ierr 0 0 0 1
lbad 00010000 0 2 0
derr 0 0 0 1
ierr 0 0 0 1
rst 0 0 0 0
derr 0 0 0 0
ierr 0 0 0 0
srd 0000 0 0 0
lbad 00008010 0 2 0
derr 0 0 0 1
irq 0 0 0 0
hbad 8000 0 0 0
irq 0 0 0 1
ld 0108 0 2 cafef00d
irq 0 0 0 1
rst 0 0 0 0
irq 0 0 0 0
